/* verilog/rv_memsys_cfg.svh */
/*
 * Memory map and timing constants for the RV32I memory subsystem.
 * Include in any module or testbench that needs the map or wait counts.
 */
`ifndef RV_MEMSYS_CFG_SVH
`define RV_MEMSYS_CFG_SVH

// 32-bit RAM words, byte range 0 .. RAM_WORDS*4-1
`define RAM_WORDS 512

// single data register of the slow peripheral
`define PERIPH_ADDR 32'h0000_1000

// access cycles with pready low before the peripheral answers
`define PERIPH_WAIT 3

`endif

/* verilog/rv_memsys_pkg.sv */
/*
 * Types shared by the memory handler, the APB fabric and the testbench.
 * Import with rv_memsys_pkg::* inside a module body.
 */
`default_nettype none

package rv_memsys_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    // func3 of loads and stores
    typedef enum logic [2:0] {
        OP_B  = 3'd0,
        OP_H  = 3'd1,
        OP_W  = 3'd2,
        OP_BU = 3'd4,
        OP_HU = 3'd5
    } mem_op_t;

    typedef enum logic [2:0] {
        ST_INC,
        ST_FETCH,
        ST_FWAIT,
        ST_LORS,
        ST_LSWAIT,
        ST_REGOP
    } handler_state_t;

    // load/store request from the core
    typedef struct packed {
        logic    read;
        logic    write;
        mem_op_t op;
        addr_t   addr;
        word_t   wdata;
    } mem_req_t;

    // master to slave
    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        word_t pwdata;
        strb_t pstrb;
    } apb_req_t;

    // slave to master
    typedef struct packed {
        logic  pready;
        logic  pslverr;
        word_t prdata;
    } apb_rsp_t;

endpackage

`default_nettype wire

/* verilog/mem_handler.sv */
/*
 * Multicycle memory handler and APB master: fetches the word at pc, then
 * runs the load or store the core requests. Store data is lane steered
 * with byte strobes; load data is lane selected and extended per func3.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_handler (
    input  logic                      clk,
    input  logic                      nrst,
    input  rv_memsys_pkg::addr_t      pc,
    input  rv_memsys_pkg::mem_req_t   req,
    input  rv_memsys_pkg::apb_rsp_t   apb_rsp,
    output rv_memsys_pkg::apb_req_t   apb_req,
    output rv_memsys_pkg::word_t      instr,
    output logic                      instr_valid,
    output rv_memsys_pkg::word_t      load_data,
    output logic                      load_valid,
    output logic                      pc_step,
    output logic                      bus_err
);
    import rv_memsys_pkg::*;

    handler_state_t state;
    handler_state_t next_state;
    apb_req_t       apb_d;
    logic           xfer_done;
    logic           err_q;
    word_t          rdata_q;
    logic [1:0]     lane;
    word_t          st_data;
    strb_t          st_strb;
    word_t          ld_shift;
    word_t          ld_ext;
    logic           misaligned;

    // transfer ends in the access cycle that sees pready
    assign xfer_done = apb_req.psel && apb_req.penable && apb_rsp.pready;
    assign lane      = req.addr[1:0];

    // store lanes: replicate, the strobes pick the byte or half
    always_comb begin
        case (req.op)
            OP_B: begin
                st_data = {4{req.wdata[7:0]}};
                st_strb = strb_t'(4'b0001 << lane);
            end
            OP_H: begin
                st_data = {2{req.wdata[15:0]}};
                st_strb = strb_t'(4'b0011 << lane);
            end
            OP_W: begin
                st_data = req.wdata;
                st_strb = 4'b1111;
            end
            default: begin
                // no store encoding, nothing written
                st_data = req.wdata;
                st_strb = 4'b0000;
            end
        endcase
    end

    // load lane select and extension
    assign ld_shift = rdata_q >> {lane, 3'b000};

    always_comb begin
        case (req.op)
            OP_B:    ld_ext = {{24{ld_shift[7]}}, ld_shift[7:0]};
            OP_H:    ld_ext = {{16{ld_shift[15]}}, ld_shift[15:0]};
            OP_BU:   ld_ext = {24'b0, ld_shift[7:0]};
            OP_HU:   ld_ext = {16'b0, ld_shift[15:0]};
            default: ld_ext = rdata_q;
        endcase
    end

    always_comb begin
        next_state = state;
        apb_d      = apb_req;
        case (state)
            ST_INC: begin
                // leave once pc_step has been seen by the core
                if (pc_step) begin
                    next_state = ST_FETCH;
                end
            end
            ST_FETCH: begin
                // setup phase of the fetch read
                apb_d.psel    = 1'b1;
                apb_d.penable = 1'b0;
                apb_d.pwrite  = 1'b0;
                apb_d.paddr   = pc;
                apb_d.pwdata  = '0;
                apb_d.pstrb   = '0;
                next_state    = ST_FWAIT;
            end
            ST_FWAIT: begin
                if (xfer_done) begin
                    apb_d.psel    = 1'b0;
                    apb_d.penable = 1'b0;
                    next_state    = ST_LORS;
                end else begin
                    apb_d.penable = 1'b1;
                end
            end
            ST_LORS: begin
                if (req.read || req.write) begin
                    apb_d.psel    = 1'b1;
                    apb_d.penable = 1'b0;
                    apb_d.pwrite  = req.write;
                    apb_d.paddr   = req.addr;
                    apb_d.pwdata  = req.write ? st_data : '0;
                    // reads carry no strobes
                    apb_d.pstrb   = req.write ? st_strb : '0;
                    next_state    = ST_LSWAIT;
                end else begin
                    next_state = ST_INC;
                end
            end
            ST_LSWAIT: begin
                if (xfer_done) begin
                    apb_d.psel    = 1'b0;
                    apb_d.penable = 1'b0;
                    next_state    = apb_req.pwrite ? ST_INC : ST_REGOP;
                end else begin
                    apb_d.penable = 1'b1;
                end
            end
            default: begin
                // ST_REGOP, result goes out on the way to ST_INC
                next_state = ST_INC;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state       <= ST_INC;
            apb_req     <= '0;
            pc_step     <= 1'b0;
            instr_valid <= 1'b0;
            load_valid  <= 1'b0;
            bus_err     <= 1'b0;
            err_q       <= 1'b0;
        end else begin
            state       <= next_state;
            apb_req     <= apb_d;
            // one pulse per entry into ST_INC
            pc_step     <= (next_state == ST_INC);
            instr_valid <= (state == ST_FWAIT) && xfer_done;
            load_valid  <= (state == ST_REGOP);
            bus_err     <= xfer_done && apb_rsp.pslverr;
            if (state == ST_LSWAIT && xfer_done) begin
                err_q <= apb_rsp.pslverr;
            end
        end
    end

    // payload captures
    always_ff @(posedge clk) begin
        if (state == ST_FWAIT && xfer_done) begin
            instr <= apb_rsp.prdata;
        end
        if (state == ST_LSWAIT && xfer_done) begin
            rdata_q <= apb_rsp.prdata;
        end
        if (state == ST_REGOP) begin
            // failed load reads as zero
            load_data <= err_q ? '0 : ld_ext;
        end
    end

    assign misaligned = ((req.op == OP_H || req.op == OP_HU) && req.addr[0])
                     || (req.op == OP_W && req.addr[1:0] != 2'b00);

    // slave may stall, master must not move
    apb_hold: assert property (@(posedge clk) disable iff (!nrst)
        (apb_req.psel && apb_req.penable && !apb_rsp.pready) |=> $stable(apb_req))
        else $error("APB request changed during wait state");

    req_rw_excl: assert property (@(posedge clk) disable iff (!nrst)
        (state == ST_LORS) |-> !(req.read && req.write))
        else $error("request with read and write both set");

    req_aligned: assert property (@(posedge clk) disable iff (!nrst)
        (state == ST_LORS && (req.read || req.write)) |-> !misaligned)
        else $error("misaligned load/store request");

endmodule

`default_nettype wire

/* verilog/apb_decoder.sv */
/*
 * APB address decoder: routes psel to the RAM or the peripheral register
 * and muxes their responses back. Unmapped addresses get an error
 * response straight from the decoder, without wait states.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_memsys_cfg.svh"

module apb_decoder (
    input  rv_memsys_pkg::apb_req_t apb_in,
    input  rv_memsys_pkg::apb_rsp_t ram_rsp,
    input  rv_memsys_pkg::apb_rsp_t reg_rsp,
    output rv_memsys_pkg::apb_req_t ram_req,
    output rv_memsys_pkg::apb_req_t reg_req,
    output rv_memsys_pkg::apb_rsp_t apb_out
);
    import rv_memsys_pkg::*;

    localparam addr_t RAM_BYTES = addr_t'(`RAM_WORDS * 4);

    logic ram_hit;
    logic reg_hit;

    assign ram_hit = (apb_in.paddr < RAM_BYTES);
    assign reg_hit = (apb_in.paddr == `PERIPH_ADDR);

    // same bus to both slaves, only psel is gated
    always_comb begin
        ram_req      = apb_in;
        ram_req.psel = apb_in.psel && ram_hit;
        reg_req      = apb_in;
        reg_req.psel = apb_in.psel && reg_hit;
    end

    // response mux
    always_comb begin
        if (ram_hit) begin
            apb_out = ram_rsp;
        end else if (reg_hit) begin
            apb_out = reg_rsp;
        end else begin
            // hole in the map, error in the first access cycle
            apb_out.pready  = apb_in.psel && apb_in.penable;
            apb_out.pslverr = apb_in.psel && apb_in.penable;
            apb_out.prdata  = '0;
        end
    end

    // peripheral must sit outside the RAM range
    sel_onehot: assert final ($onehot0({ram_req.psel, reg_req.psel}))
        else $error("more than one APB slave selected");

endmodule

`default_nettype wire

/* verilog/apb_ram.sv */
/*
 * Word RAM behind APB with byte-strobe writes.
 * Every access gets one wait state, so pready rises in the second
 * access cycle and writes land on that edge.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_memsys_cfg.svh"

module apb_ram (
    input  logic                    clk,
    input  logic                    nrst,
    input  rv_memsys_pkg::apb_req_t apb_in,
    output rv_memsys_pkg::apb_rsp_t apb_out
);
    import rv_memsys_pkg::*;

    localparam int IDX_W = $clog2(`RAM_WORDS);

    word_t            mem [`RAM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             access;
    logic             wait_q;
    logic             xfer;

    // word index without the byte offset
    assign idx    = apb_in.paddr[IDX_W+1:2];
    assign access = apb_in.psel && apb_in.penable;
    // second access cycle
    assign xfer   = access && wait_q;

    assign apb_out.pready  = xfer;
    assign apb_out.pslverr = 1'b0;
    assign apb_out.prdata  = mem[idx];

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wait_q <= 1'b0;
            for (int i = 0; i < `RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            // set in the first access cycle and cleared when the transfer ends
            wait_q <= access && !wait_q;
            if (xfer && apb_in.pwrite) begin
                // only strobed bytes change
                for (int b = 0; b < 4; b++) begin
                    if (apb_in.pstrb[b]) begin
                        mem[idx][8*b +: 8] <= apb_in.pwdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/apb_slow_reg.sv */
/*
 * Slow peripheral with one byte-writable data register on APB.
 * Holds pready low for `PERIPH_WAIT access cycles on every transfer.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_memsys_cfg.svh"

module apb_slow_reg (
    input  logic                    clk,
    input  logic                    nrst,
    input  rv_memsys_pkg::apb_req_t apb_in,
    output rv_memsys_pkg::apb_rsp_t apb_out
);
    import rv_memsys_pkg::*;

    localparam int CNT_W = (`PERIPH_WAIT > 0) ? $clog2(`PERIPH_WAIT + 1) : 1;
    localparam logic [CNT_W-1:0] WAIT_MAX = CNT_W'(`PERIPH_WAIT);

    word_t            data_q;
    logic [CNT_W-1:0] wait_cnt;
    logic             access;
    logic             xfer;

    assign access = apb_in.psel && apb_in.penable;
    // device done after the wait count
    assign xfer   = access && (wait_cnt == WAIT_MAX);

    assign apb_out.pready  = xfer;
    assign apb_out.pslverr = 1'b0;
    assign apb_out.prdata  = data_q;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wait_cnt <= '0;
            data_q   <= 32'hA5A5_0F0F;
        end else begin
            if (access && !xfer) begin
                wait_cnt <= wait_cnt + 1'b1;
            end else begin
                wait_cnt <= '0;
            end
            if (xfer && apb_in.pwrite) begin
                for (int b = 0; b < 4; b++) begin
                    if (apb_in.pstrb[b]) begin
                        data_q[8*b +: 8] <= apb_in.pwdata[8*b +: 8];
                    end
                end
            end
        end
    end

    wait_bound: assert property (@(posedge clk) disable iff (!nrst)
        wait_cnt <= WAIT_MAX)
        else $error("peripheral wait counter overran");

endmodule

`default_nettype wire

/* verilog/rv_memsys_top.sv */
/*
 * Memory subsystem top: memory handler as APB master, address decoder,
 * word RAM and slow peripheral register. The core side drives pc and req.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_memsys_top (
    input  logic                    clk,
    input  logic                    nrst,
    input  rv_memsys_pkg::addr_t    pc,
    input  rv_memsys_pkg::mem_req_t req,
    output rv_memsys_pkg::word_t    instr,
    output logic                    instr_valid,
    output rv_memsys_pkg::word_t    load_data,
    output logic                    load_valid,
    output logic                    pc_step,
    output logic                    bus_err
);
    import rv_memsys_pkg::*;

    // master side of the decoder
    apb_req_t hnd_req;
    apb_rsp_t hnd_rsp;
    // slave side
    apb_req_t ram_req;
    apb_rsp_t ram_rsp;
    apb_req_t reg_req;
    apb_rsp_t reg_rsp;

    mem_handler u_handler (
        .clk         (clk),
        .nrst        (nrst),
        .pc          (pc),
        .req         (req),
        .apb_rsp     (hnd_rsp),
        .apb_req     (hnd_req),
        .instr       (instr),
        .instr_valid (instr_valid),
        .load_data   (load_data),
        .load_valid  (load_valid),
        .pc_step     (pc_step),
        .bus_err     (bus_err)
    );

    apb_decoder u_decoder (
        .apb_in  (hnd_req),
        .ram_rsp (ram_rsp),
        .reg_rsp (reg_rsp),
        .ram_req (ram_req),
        .reg_req (reg_req),
        .apb_out (hnd_rsp)
    );

    apb_ram u_ram (
        .clk     (clk),
        .nrst    (nrst),
        .apb_in  (ram_req),
        .apb_out (ram_rsp)
    );

    apb_slow_reg u_slow_reg (
        .clk     (clk),
        .nrst    (nrst),
        .apb_in  (reg_req),
        .apb_out (reg_rsp)
    );

endmodule

`default_nettype wire

/* sim/tb_rv_memsys.sv */
/*
 * Testbench for the memory subsystem: plays the core, issues random
 * loads, stores and no-ops from an LFSR and checks fetches and loads
 * against a RAM and peripheral model kept here.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_memsys_cfg.svh"

module tb_rv_memsys;
    import rv_memsys_pkg::*;

    localparam int NUM_REQ    = 300;
    localparam int MAX_CYCLES = NUM_REQ * 20;
    localparam int RAM_BYTES  = `RAM_WORDS * 4;

    logic     clk;
    logic     nrst;
    addr_t    pc;
    mem_req_t req;
    word_t    instr;
    logic     instr_valid;
    word_t    load_data;
    logic     load_valid;
    logic     pc_step;
    logic     bus_err;

    // model and bookkeeping
    word_t       model_ram [`RAM_WORDS];
    word_t       model_reg;
    word_t       exp_data;
    logic [31:0] lfsr;
    logic        done, in_flight, exp_load, exp_err, seen_load, seen_err, step_pending;
    int          cycles, errors, checks, closed, model_loads;
    int          step_count, instr_count, load_count;

    rv_memsys_top UUT (
        .clk         (clk),
        .nrst        (nrst),
        .pc          (pc),
        .req         (req),
        .instr       (instr),
        .instr_valid (instr_valid),
        .load_data   (load_data),
        .load_valid  (load_valid),
        .pc_step     (pc_step),
        .bus_err     (bus_err)
    );

    always #20 clk = ~clk;

    // galois form, taps 32,22,2,1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit
    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic mem_op_t pick_load_op(input logic [2:0] v);
        case (v)
            3'd0, 3'd5: return OP_B;
            3'd1, 3'd6: return OP_H;
            3'd3:       return OP_BU;
            3'd4:       return OP_HU;
            default:    return OP_W;
        endcase
    endfunction

    // bytes of wdata replace lanes starting at the byte offset
    function automatic word_t store_merge(word_t old, word_t wdata, mem_op_t op,
                                          logic [1:0] lane);
        int    size;
        word_t res;
        size = (op == OP_B) ? 1 : (op == OP_H) ? 2 : 4;
        res  = old;
        for (int b = 0; b < 4; b++) begin
            if (b >= lane && b < lane + size) begin
                res[8*b +: 8] = wdata[8*(b-lane) +: 8];
            end
        end
        return res;
    endfunction

    function automatic word_t load_extract(word_t w, mem_op_t op, logic [1:0] lane);
        word_t s;
        s = w >> (8 * lane);
        case (op)
            OP_B:    return {{24{s[7]}}, s[7:0]};
            OP_H:    return {{16{s[15]}}, s[15:0]};
            OP_BU:   return {24'h0, s[7:0]};
            OP_HU:   return {16'h0, s[15:0]};
            default: return w;
        endcase
    endfunction

    // new request, expectations worked out and stores applied to the model
    task automatic issue_request();
        logic [31:0] kind, opb, off, region, idx, data;
        mem_req_t    r;
        word_t       old;
        logic        ram_hit, reg_hit;
        r = '0;
        draw(3, kind);
        r.read  = (kind < 3);
        r.write = (kind >= 3 && kind < 6);
        if (r.read) begin
            draw(3, opb);
            r.op = pick_load_op(opb[2:0]);
        end else begin
            draw(2, opb);
            case (opb[1:0])
                2'd0:    r.op = OP_B;
                2'd1:    r.op = OP_H;
                default: r.op = OP_W;
            endcase
        end
        // byte offset aligned to the access size
        case (r.op)
            OP_B, OP_BU: draw(2, off);
            OP_H, OP_HU: begin
                draw(1, off);
                off = off << 1;
            end
            default: off = 0;
        endcase
        draw(4, region);
        if (region < 13) begin
            // small window so loads hit earlier stores
            draw(5, idx);
            r.addr = (idx << 2) + off;
        end else if (region < 15) begin
            r.addr = `PERIPH_ADDR;
        end else begin
            draw(10, idx);
            r.addr = 32'h2000 + (idx << 2) + off;
        end
        draw(32, data);
        r.wdata = data;
        ram_hit = (r.addr < RAM_BYTES);
        reg_hit = (r.addr == `PERIPH_ADDR);
        old = ram_hit ? model_ram[r.addr >> 2] : reg_hit ? model_reg : '0;
        exp_err  = (r.read || r.write) && !ram_hit && !reg_hit;
        exp_load = r.read;
        exp_data = exp_err ? '0 : load_extract(old, r.op, r.addr[1:0]);
        if (r.write && ram_hit) begin
            model_ram[r.addr >> 2] = store_merge(old, r.wdata, r.op, r.addr[1:0]);
        end else if (r.write && reg_hit) begin
            model_reg = store_merge(old, r.wdata, r.op, r.addr[1:0]);
        end
        if (r.read) begin
            model_loads++;
        end
        req       = r;
        in_flight = 1'b1;
        seen_load = 1'b0;
        seen_err  = 1'b0;
    endtask

    // next pc_step ends the request
    task automatic close_request();
        checks++;
        assert (seen_load == exp_load && seen_err == exp_err) else begin
            errors++;
            $display("request %0d ended with load_valid %0b bus_err %0b, wanted %0b and %0b",
                     closed, seen_load, seen_err, exp_load, exp_err);
        end
        in_flight = 1'b0;
        closed++;
        if (closed == NUM_REQ) begin
            done = 1'b1;
        end
    endtask

    // sample outputs and drive inputs on the falling edge
    always @(negedge clk) begin
        cycles <= cycles + 1;
        if (nrst && !done) begin
            // pc moves in the cycle after pc_step
            if (step_pending) begin
                pc = (pc + 4 >= RAM_BYTES) ? '0 : pc + 4;
                step_pending = 1'b0;
            end
            if (load_valid) begin
                load_count++;
                checks++;
                assert (in_flight && exp_load && !seen_load) else begin
                    errors++;
                    $display("load_valid at %0t with no load outstanding", $time);
                end
                if (exp_load) begin
                    assert (load_data === exp_data) else begin
                        errors++;
                        $display("FAILED at %0t: load op %0d addr %h gave %h, expected %h",
                                 $time, req.op, req.addr, load_data, exp_data);
                    end
                end
                seen_load = 1'b1;
            end
            if (bus_err) begin
                checks++;
                assert (in_flight && exp_err) else begin
                    errors++;
                    $display("FAILED at %0t: bus_err on addr %h", $time, req.addr);
                end
                seen_err = 1'b1;
            end
            if (pc_step) begin
                step_count++;
                step_pending = 1'b1;
                if (in_flight) begin
                    close_request();
                end
            end
            if (instr_valid && !done) begin
                instr_count++;
                checks++;
                assert (step_count > 0 && !in_flight) else begin
                    errors++;
                    $display("instr_valid at %0t out of order with pc_step", $time);
                end
                assert (instr === model_ram[pc >> 2]) else begin
                    errors++;
                    $display("FAILED at %0t: fetch at pc %h gave %h, expected %h",
                             $time, pc, instr, model_ram[pc >> 2]);
                end
                issue_request();
            end
        end
    end

    initial begin
        clk = 1'b0;
        nrst = 1'b0;
        pc = '0;
        req = '0;
        lfsr = 32'h296c;
        model_reg = 32'hA5A5_0F0F;
        for (int i = 0; i < `RAM_WORDS; i++) begin
            model_ram[i] = '0;
        end
        {done, in_flight, exp_load, exp_err, seen_load, seen_err, step_pending} = '0;
        exp_data = '0;
        {cycles, errors, checks, closed, model_loads} = '0;
        {step_count, instr_count, load_count} = '0;
        repeat (8) @(negedge clk);
        nrst = 1'b1;
        while (!done && cycles < MAX_CYCLES) begin
            @(posedge clk);
        end
        if (!done) begin
            errors++;
            $display("timeout after %0d cycles, %0d of %0d requests finished",
                     cycles, closed, NUM_REQ);
        end
        // no lost or repeated transactions
        assert (step_count == NUM_REQ + 1 && instr_count == NUM_REQ) else begin
            errors++;
            $display("FAILED at %0t: %0d pc_step and %0d instr_valid for %0d requests",
                     $time, step_count, instr_count, NUM_REQ);
        end
        assert (load_count == model_loads) else begin
            errors++;
            $display("FAILED at %0t: %0d load_valid, expected %0d",
                     $time, load_count, model_loads);
        end
        $display("requests %0d, loads %0d, pc_step %0d, instr_valid %0d, checks %0d, errors %0d",
                 closed, load_count, step_count, instr_count, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rv_memsys.f */
+incdir+verilog
verilog/rv_memsys_pkg.sv
verilog/mem_handler.sv
verilog/apb_decoder.sv
verilog/apb_ram.sv
verilog/apb_slow_reg.sv
verilog/rv_memsys_top.sv
sim/tb_rv_memsys.sv
